//--- files.f
hw/ula_fx_cmd_pkg.sv
hw/ula_fx_num_pkg.sv
hw/ula_fx_int_unit.sv
hw/ula_fx_float_unit.sv
hw/ula_fx_regs.sv
hw/ula_fx_job_fifo.sv
hw/ula_fx_exec.sv
hw/ula_fx_top.sv
sim/tb_ula_fx.sv

//--- Makefile
# Verilator simulation of the ULA FX AXI4-Lite arithmetic unit

VERILATOR ?= verilator
TOP       ?= tb_ula_fx
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal
PASS_MSG  ?= Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/tb_ula_fx.sv
/*
 * ULA FX testbench
 * Drives the AXI4-Lite slave, predicts results from the op rules
 * and compares every RESULT read in a monitor process
 */

`default_nettype none

module tb_ula_fx;

	timeunit 1ns;
	timeprecision 1ps;

	import ula_fx_cmd_pkg::*;

	localparam int FIFO_DEPTH   = 4;
	localparam int NU_GAIN      = 64;
	localparam int SEED         = 32'h34e7;
	localparam int N_RAND       = 6;     // Random jobs per op
	localparam int STALL_CYCLES = 40;
	localparam int JOB_CYCLES   = 60;    // Generous bound for one full job
	localparam int N_JOBS       = 29 * N_RAND + 42 + FIFO_DEPTH;
	localparam int CYCLE_LIMIT  = N_JOBS * JOB_CYCLES + STALL_CYCLES + 200;

	logic              clk = 1'b0;
	logic              arst_n;
	logic [ADDR_W-1:0] awaddr;
	logic              awvalid;
	logic              awready;
	logic [DATA_W-1:0] wdata;
	logic              wvalid;
	logic              wready;
	logic [1:0]        bresp;
	logic              bvalid;
	logic              bready;
	logic [ADDR_W-1:0] araddr;
	logic              arvalid;
	logic              arready;
	logic [DATA_W-1:0] rdata;
	logic [1:0]        rresp;
	logic              rvalid;
	logic              rready;

	logic [DATA_W-1:0] exp_q[$];      // Expected results in job order
	logic [OP_W-1:0]   exp_op_q[$];
	logic [ADDR_W-1:0] rd_addr_q[$];  // Addresses of reads in flight
	int                n_checks = 0;
	int                n_errors = 0;
	int                n_tests  = 0;
	int                t_checks;
	int                t_errors;
	int                cycles   = 0;
	logic              stall_done;

	always #10 clk = ~clk;

	ula_fx_top #(
		.FIFO_DEPTH(FIFO_DEPTH),
		.NU_GAIN   (NU_GAIN)
	) i_ula_fx_top (
		.clk    (clk),
		.arst_n (arst_n),
		.awaddr (awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata  (wdata),
		.wvalid (wvalid),
		.wready (wready),
		.bresp  (bresp),
		.bvalid (bvalid),
		.bready (bready),
		.araddr (araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata  (rdata),
		.rresp  (rresp),
		.rvalid (rvalid),
		.rready (rready)
	);

	// **************************************************
	// Expected result of one job
	// **************************************************
	function automatic logic [DATA_W-1:0] ula_ref(input logic [OP_W-1:0] op,
			input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
		longint      sa;
		longint      sb;
		longint      r;
		int          ea;
		int          eb;
		logic [8:0]  ew;
		logic [45:0] mp;
		sa = $signed(a);
		sb = $signed(b);
		ea = $signed(a[30:23]);
		eb = $signed(b[30:23]);
		ew = 9'(ea + eb + 23);              // Wide exponent, one guard bit
		mp = 46'(a[22:0]) * 46'(b[22:0]);
		r  = 0;
		case (op)
			OP_NOP:  r = sb;
			OP_LOAD: r = sa;
			OP_ADD:  r = sa + sb;
			OP_MLT:  r = sa * sb;
			OP_DIV:  r = (sb == 0) ? 0 : sa / sb;
			OP_MOD:  r = (sb == 0) ? 0 : sa % sb;
			OP_NEG:  r = -sb;
			OP_NRM:  r = sb / NU_GAIN;
			OP_ABS:  r = (sb < 0) ? -sb : sb;
			OP_PST:  r = (sb < 0) ? 0 : sb;
			OP_SGN:  r = ((sa < 0) == (sb < 0)) ? sb : -sb;
			OP_OR:   r = sa | sb;
			OP_AND:  r = sa & sb;
			OP_INV:  r = ~sb;
			OP_XOR:  r = sa ^ sb;
			OP_LES:  r = (sa < sb) ? 1 : 0;
			OP_GRE:  r = (sa > sb) ? 1 : 0;
			OP_EQU:  r = (sa == sb) ? 1 : 0;
			OP_LIN:  r = (sb == 0) ? 1 : 0;
			OP_LAN:  r = (sa != 0 && sb != 0) ? 1 : 0;
			OP_LOR:  r = (sa != 0 || sb != 0) ? 1 : 0;
			OP_SHL:  r = (b >= DATA_W) ? 0 : sa << b;
			OP_SHR:  r = (b >= DATA_W) ? 0 : a >> b;
			OP_SRS:  r = (b >= DATA_W) ? ((sa < 0) ? -1 : 0) : sa >>> b;
			OP_FNEG: r = {~b[31], b[30:0]};
			OP_FABS: r = {1'b0, b[30:0]};
			OP_FSGN: r = {a[31], b[30:0]};
			OP_FPST: r = b[31] ? 32'h4000_0000 : b;
			OP_FMLT: r = {a[31] ^ b[31], ew[7:0], (ew[8:7] == 2'b10) ? 23'd0 : mp[45:23]};
			default: r = 0;
		endcase
		return r[DATA_W-1:0];
	endfunction

	task automatic check_eq(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
			input string what);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	// **************************************************
	// Bus tasks
	// **************************************************
	task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
			output logic [1:0] resp);
		@(posedge clk);
		awaddr  <= addr;
		awvalid <= 1'b1;
		wdata   <= data;
		wvalid  <= 1'b1;
		bready  <= 1'b1;
		do begin
			@(posedge clk);
		end while (!awready);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		do begin
			@(posedge clk);
		end while (!bvalid);
		resp = bresp;
		bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
			output logic [1:0] resp);
		@(posedge clk);
		araddr  <= addr;
		arvalid <= 1'b1;
		rready  <= 1'b1;
		do begin
			@(posedge clk);
		end while (!arready);
		arvalid <= 1'b0;
		do begin
			@(posedge clk);
		end while (!rvalid);
		data = rdata;
		resp = rresp;
		rready <= 1'b0;
	endtask

	// Operands, then the op write that launches the job
	task automatic issue_job(input logic [OP_W-1:0] op, input logic [DATA_W-1:0] a,
			input logic [DATA_W-1:0] b);
		logic [1:0] resp;
		axi_write(REG_IN1, a, resp);
		check_eq(resp, RESP_OKAY, "in1 write response");
		axi_write(REG_IN2, b, resp);
		check_eq(resp, RESP_OKAY, "in2 write response");
		exp_q.push_back(ula_ref(op, a, b));
		exp_op_q.push_back(op);
		axi_write(REG_OP, DATA_W'(op), resp);
		check_eq(resp, RESP_OKAY, "op write response");
	endtask

	task automatic wait_result(output logic [DATA_W-1:0] stat);
		logic [1:0] resp;
		do begin
			axi_read(REG_STATUS, stat, resp);
		end while (!stat[STAT_VALID]);
	endtask

	task automatic run_job(input logic [OP_W-1:0] op, input logic [DATA_W-1:0] a,
			input logic [DATA_W-1:0] b);
		logic [DATA_W-1:0] exp;
		logic [DATA_W-1:0] stat;
		logic [DATA_W-1:0] data;
		logic [1:0]        resp;
		exp = ula_ref(op, a, b);
		issue_job(op, a, b);
		wait_result(stat);
		check_eq(stat[STAT_ZERO], exp == '0, $sformatf("zero bit of op %0d", op));
		axi_read(REG_RESULT, data, resp);   // Value checked by the monitor
		check_eq(resp, RESP_OKAY, "result response");
		axi_read(REG_STATUS, stat, resp);
		check_eq(stat[STAT_VALID], 1'b0, "valid after result read");
	endtask

	// Compares each RESULT read with the oldest expected value
	always @(posedge clk) begin : result_monitor
		logic [ADDR_W-1:0] addr;
		logic [OP_W-1:0]   op;
		if (arvalid && arready) begin
			rd_addr_q.push_back(araddr);
		end
		if (rvalid && rready && rd_addr_q.size() > 0) begin
			addr = rd_addr_q.pop_front();
			if (addr == REG_RESULT && rresp == RESP_OKAY) begin
				if (exp_q.size() == 0) begin
					n_errors++;
					$display("result read at %0t ns with no job outstanding", $time);
				end else begin
					op = exp_op_q.pop_front();
					check_eq(rdata, exp_q.pop_front(), $sformatf("result of op %0d", op));
				end
			end
		end
	end

	always @(posedge clk) begin : watchdog
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, a bus handshake never completed", cycles);
			$display("Result: FAILED");
			$finish;
		end
	end

	task automatic begin_test();
		t_checks = n_checks;
		t_errors = n_errors;
	endtask

	task automatic end_test(input string name);
		@(posedge clk);   // Let the monitor finish the last compare
		n_tests++;
		$display("test %-7s %s: %0d checks, %0d errors", name,
			(n_errors == t_errors) ? "ok" : "bad", n_checks - t_checks, n_errors - t_errors);
	endtask

	// **************************************************
	// Tests
	// **************************************************
	task automatic test_reset();
		logic [DATA_W-1:0] stat;
		logic [1:0]        resp;
		begin_test();
		check_eq({awready, wready, bvalid, arready, rvalid}, '0, "outputs after reset");
		axi_read(REG_STATUS, stat, resp);
		check_eq(stat, '0, "status after reset");
		end_test("reset");
	endtask

	task automatic test_int();
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		begin_test();
		for (int op = 0; op <= OP_SRS; op++) begin
			for (int i = 0; i < N_RAND; i++) begin
				a = $urandom;
				b = $urandom;
				if (op >= OP_SHL && i < N_RAND - 2) begin
					b = $urandom_range(0, 31);   // Mostly in-range shifts
				end
				run_job(OP_W'(op), a, b);
			end
		end
		run_job(OP_DIV, 32'd7, 32'd0);
		run_job(OP_MOD, 32'd7, 32'd0);
		run_job(OP_DIV, -32'sd7, 32'd2);
		run_job(OP_MOD, -32'sd7, 32'd2);
		run_job(OP_NRM, 32'd0, -32'sd1);
		run_job(OP_NRM, 32'd0, -32'sd63);
		run_job(OP_NRM, 32'd0, -32'sd64);
		run_job(OP_NRM, 32'd0, -32'sd65);
		run_job(OP_NRM, 32'd0, -32'sd1000);
		run_job(OP_SHL, 32'hDEAD_BEEF, 32'd32);
		run_job(OP_SHR, 32'h8000_0000, 32'd32);
		run_job(OP_SRS, 32'h8000_0000, 32'd32);
		run_job(OP_SRS, -32'sd8, 32'hFFFF_FFFF);
		run_job(OP_SRS, -32'sd8, 32'd1);
		run_job(OP_EQU, 32'd5, 32'd5);
		run_job(OP_LAN, 32'd0, 32'd3);
		run_job(OP_LOR, 32'd0, 32'd0);
		run_job(OP_LIN, 32'd9, 32'd0);
		run_job(OP_ABS, 32'd0, 32'h8000_0000);
		end_test("int");
	endtask

	task automatic test_float();
		logic [OP_W-1:0] flt_ops[5];
		flt_ops = '{OP_FNEG, OP_FABS, OP_FSGN, OP_FPST, OP_FMLT};
		begin_test();
		foreach (flt_ops[k]) begin
			for (int i = 0; i < N_RAND; i++) begin
				run_job(flt_ops[k], $urandom, $urandom);
			end
		end
		run_job(OP_FMLT, 32'h4040_0000, 32'h4040_0000);   // Exponents -128, underflow
		run_job(OP_FMLT, 32'h0240_0000, 32'h8170_0000);
		run_job(OP_FPST, 32'd0, 32'hBF80_0000);
		run_job(OP_FPST, 32'd0, 32'h3F80_0000);
		run_job(OP_FSGN, 32'h8000_0000, 32'h1234_5678);
		run_job(OP_FABS, 32'd0, 32'hFFFF_FFFF);
		end_test("float");
	endtask

	task automatic test_status();
		begin_test();
		run_job(OP_ADD, 32'd5, -32'sd5);
		run_job(OP_ADD, 32'd5, 32'd6);
		run_job(OP_LIN, 32'd0, 32'd0);
		run_job(OP_FNEG, 32'd0, 32'd0);       // Sign bit only, not zero
		run_job(OP_AND, 32'h0000_00F0, 32'h0000_000F);
		end_test("status");
	endtask

	// Fill the slot and the queue, then one more op write must wait
	task automatic test_queue();
		logic [DATA_W-1:0] stat;
		logic [DATA_W-1:0] data;
		logic [1:0]        resp;
		begin_test();
		for (int i = 0; i <= FIFO_DEPTH; i++) begin
			issue_job(OP_ADD + OP_W'(i), $urandom, $urandom);
			axi_read(REG_STATUS, stat, resp);
			check_eq(stat[DATA_W-1:4] <= FIFO_DEPTH, 1'b1, "queue level bound");
		end
		check_eq(stat[DATA_W-1:4], FIFO_DEPTH, "queue level when full");
		stall_done = 1'b0;
		fork
			begin
				issue_job(OP_SGN, $urandom, $urandom);
				stall_done = 1'b1;
			end
		join_none
		repeat (STALL_CYCLES) @(posedge clk);
		check_eq(stall_done, 1'b0, "op write held off while queue full");
		for (int i = 0; i <= FIFO_DEPTH + 1; i++) begin
			wait_result(stat);
			check_eq(stat[DATA_W-1:4] <= FIFO_DEPTH, 1'b1, "queue level bound");
			axi_read(REG_RESULT, data, resp);
			check_eq(resp, RESP_OKAY, "queued result response");
		end
		wait (stall_done);
		@(posedge clk);
		check_eq(exp_q.size(), 0, "expected results left over");
		end_test("queue");
	endtask

	task automatic test_errors();
		logic [DATA_W-1:0] data;
		logic [1:0]        resp;
		begin_test();
		run_job(6'd24, $urandom, $urandom);   // Undefined codes give zero
		run_job(6'd30, $urandom, $urandom);
		run_job(6'd33, $urandom, $urandom);
		run_job(6'd63, $urandom, $urandom);
		axi_read(REG_RESULT, data, resp);
		check_eq(data, '0, "empty result data");
		check_eq(resp, RESP_SLVERR, "empty result response");
		axi_write(REG_STATUS, 32'h1, resp);
		check_eq(resp, RESP_SLVERR, "status write response");
		axi_write(REG_RESULT, 32'h1, resp);
		check_eq(resp, RESP_SLVERR, "result write response");
		axi_write(5'h14, 32'h1, resp);
		check_eq(resp, RESP_SLVERR, "unmapped write response");
		axi_read(REG_IN1, data, resp);
		check_eq(resp, RESP_SLVERR, "in1 read response");
		axi_read(REG_OP, data, resp);
		check_eq(resp, RESP_SLVERR, "op read response");
		end_test("errors");
	endtask

	initial begin : stimulus
		void'($urandom(SEED));
		arst_n  = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);
		test_reset();
		test_int();
		test_float();
		test_status();
		test_queue();
		test_errors();
		$display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/ula_fx_top.sv
/*
 * ULA FX top level
 * AXI4-Lite slave: write side, job queue and execution stage
 */

`default_nettype none

module ula_fx_top #(
	parameter int FIFO_DEPTH = 4,
	parameter int NU_GAIN    = 64
) (
	input  wire                                clk,
	input  wire                                arst_n,
	input  wire  [ula_fx_cmd_pkg::ADDR_W-1:0] awaddr,
	input  wire                                awvalid,
	output logic                               awready,
	input  wire  [ula_fx_cmd_pkg::DATA_W-1:0] wdata,
	input  wire                                wvalid,
	output logic                               wready,
	output logic [1:0]                         bresp,
	output logic                               bvalid,
	input  wire                                bready,
	input  wire  [ula_fx_cmd_pkg::ADDR_W-1:0] araddr,
	input  wire                                arvalid,
	output logic                               arready,
	output logic [ula_fx_cmd_pkg::DATA_W-1:0] rdata,
	output logic [1:0]                         rresp,
	output logic                               rvalid,
	input  wire                                rready
);

	import ula_fx_cmd_pkg::*;

	localparam int LVL_W = $clog2(FIFO_DEPTH + 1);

	logic              push;
	logic [OP_W-1:0]   push_op;
	logic [DATA_W-1:0] push_in1;
	logic [DATA_W-1:0] push_in2;
	logic              full;
	logic              pop;
	logic [OP_W-1:0]   pop_op;
	logic [DATA_W-1:0] pop_in1;
	logic [DATA_W-1:0] pop_in2;
	logic              empty;
	logic [LVL_W-1:0]  level;
	logic [DATA_W-5:0] level_w;   // Level as placed in the status word

	assign level_w = {{(DATA_W - 4 - LVL_W){1'b0}}, level};

	ula_fx_regs i_regs (
		.clk     (clk),
		.arst_n  (arst_n),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.full    (full),
		.push    (push),
		.push_op (push_op),
		.push_in1(push_in1),
		.push_in2(push_in2)
	);

	ula_fx_job_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) i_job_fifo (
		.clk     (clk),
		.arst_n  (arst_n),
		.push    (push),
		.push_op (push_op),
		.push_in1(push_in1),
		.push_in2(push_in2),
		.pop     (pop),
		.pop_op  (pop_op),
		.pop_in1 (pop_in1),
		.pop_in2 (pop_in2),
		.full    (full),
		.empty   (empty),
		.level   (level)
	);

	ula_fx_exec #(
		.NU_GAIN(NU_GAIN)
	) i_exec (
		.clk    (clk),
		.arst_n (arst_n),
		.pop_op (pop_op),
		.pop_in1(pop_in1),
		.pop_in2(pop_in2),
		.empty  (empty),
		.level  (level_w),
		.pop    (pop),
		.araddr (araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata  (rdata),
		.rresp  (rresp),
		.rvalid (rvalid),
		.rready (rready)
	);

endmodule

`default_nettype wire

//--- hw/ula_fx_exec.sv
/*
 * ULA FX execution stage
 * Pops jobs, holds one result with its zero flag, serves AXI4-Lite reads
 */

`default_nettype none

module ula_fx_exec #(
	parameter int NU_GAIN = 64
) (
	input  wire                                clk,
	input  wire                                arst_n,
	input  wire  [ula_fx_cmd_pkg::OP_W-1:0]   pop_op,
	input  wire  [ula_fx_cmd_pkg::DATA_W-1:0] pop_in1,
	input  wire  [ula_fx_cmd_pkg::DATA_W-1:0] pop_in2,
	input  wire                                empty,
	input  wire  [ula_fx_cmd_pkg::DATA_W-5:0] level,
	output logic                               pop,
	input  wire  [ula_fx_cmd_pkg::ADDR_W-1:0] araddr,
	input  wire                                arvalid,
	output logic                               arready,
	output logic [ula_fx_cmd_pkg::DATA_W-1:0] rdata,
	output logic [1:0]                         rresp,
	output logic                               rvalid,
	input  wire                                rready
);

	import ula_fx_cmd_pkg::*;
	import ula_fx_num_pkg::*;

	logic signed [DATA_W-1:0] int_res;
	ula_float_s               flt_res;
	ula_word_u                res_d;
	ula_word_u                res_q;
	logic                     res_vld;   // Result slot occupied
	logic                     zero_q;
	logic                     is_flt;
	logic                     ar_fire;
	logic                     rd_result;
	logic [DATA_W-1:0]        stat_w;

	ula_fx_int_unit #(
		.NU_GAIN(NU_GAIN)
	) i_int_unit (
		.op    (pop_op),
		.in1   (pop_in1),
		.in2   (pop_in2),
		.result(int_res)
	);

	ula_fx_float_unit i_float_unit (
		.op    (pop_op),
		.in1   (pop_in1),
		.in2   (pop_in2),
		.result(flt_res)
	);

	assign is_flt = (pop_op inside {OP_FNEG, OP_FABS, OP_FSGN, OP_FPST, OP_FMLT});

	always_comb begin
		if (is_flt) begin
			res_d.f = flt_res;
		end else begin
			res_d.i = int_res;   // Undefined codes come out as zero
		end
	end

	// **************************************************
	// Result slot
	// **************************************************
	assign pop = !empty && !res_vld;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			res_vld <= 1'b0;
			res_q   <= '0;
			zero_q  <= 1'b0;
		end else if (pop) begin
			res_vld <= 1'b1;
			res_q   <= res_d;
			zero_q  <= (res_d.i == '0);
		end else if (rd_result) begin
			res_vld <= 1'b0;
		end
	end

	// **************************************************
	// Read channels
	// **************************************************
	assign ar_fire   = arvalid && arready;
	assign rd_result = ar_fire && (araddr == REG_RESULT) && res_vld;

	always_comb begin
		stat_w             = '0;
		stat_w[STAT_VALID] = res_vld;
		stat_w[STAT_ZERO]  = zero_q;
		stat_w[DATA_W-1:4] = level;     // Queue level
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			arready <= arvalid && !arready && !rvalid;
			if (ar_fire) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ar_fire) begin
			case (araddr)
				REG_RESULT: begin
					rdata <= res_vld ? res_q.i : '0;
					rresp <= res_vld ? RESP_OKAY : RESP_SLVERR;
				end
				REG_STATUS: begin
					rdata <= stat_w;
					rresp <= RESP_OKAY;
				end
				default: begin   // Operand and op registers are write only
					rdata <= '0;
					rresp <= RESP_SLVERR;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/ula_fx_job_fifo.sv
/*
 * ULA FX job queue
 * Circular buffer of pending jobs, each one op code and two operands
 */

`default_nettype none

module ula_fx_job_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  wire                                  clk,
	input  wire                                  arst_n,
	input  wire                                  push,
	input  wire  [ula_fx_cmd_pkg::OP_W-1:0]     push_op,
	input  wire  [ula_fx_cmd_pkg::DATA_W-1:0]   push_in1,
	input  wire  [ula_fx_cmd_pkg::DATA_W-1:0]   push_in2,
	input  wire                                  pop,
	output logic [ula_fx_cmd_pkg::OP_W-1:0]     pop_op,
	output logic [ula_fx_cmd_pkg::DATA_W-1:0]   pop_in1,
	output logic [ula_fx_cmd_pkg::DATA_W-1:0]   pop_in2,
	output logic                                 full,
	output logic                                 empty,
	output logic [$clog2(FIFO_DEPTH + 1)-1:0]   level
);

	import ula_fx_cmd_pkg::*;

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int LVL_W = $clog2(FIFO_DEPTH + 1);

	logic [OP_W-1:0]   op_mem  [FIFO_DEPTH];
	logic [DATA_W-1:0] in1_mem [FIFO_DEPTH];
	logic [DATA_W-1:0] in2_mem [FIFO_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic              do_push;
	logic              do_pop;

	// Wraps at any depth, not only powers of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full    = (level == LVL_W'(FIFO_DEPTH));
	assign empty   = (level == '0);
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			case ({do_push, do_pop})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;      // Both or neither
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			op_mem[wr_ptr]  <= push_op;
			in1_mem[wr_ptr] <= push_in1;
			in2_mem[wr_ptr] <= push_in2;
		end
	end

	// Head entry always visible
	assign pop_op  = op_mem[rd_ptr];
	assign pop_in1 = in1_mem[rd_ptr];
	assign pop_in2 = in2_mem[rd_ptr];

endmodule

`default_nettype wire

//--- hw/ula_fx_regs.sv
/*
 * ULA FX write side
 * AXI4-Lite write channels, operand registers and job launch
 */

`default_nettype none

module ula_fx_regs (
	input  wire                                clk,
	input  wire                                arst_n,
	input  wire  [ula_fx_cmd_pkg::ADDR_W-1:0] awaddr,
	input  wire                                awvalid,
	output logic                               awready,
	input  wire  [ula_fx_cmd_pkg::DATA_W-1:0] wdata,
	input  wire                                wvalid,
	output logic                               wready,
	output logic [1:0]                         bresp,
	output logic                               bvalid,
	input  wire                                bready,
	input  wire                                full,
	output logic                               push,
	output logic [ula_fx_cmd_pkg::OP_W-1:0]   push_op,
	output logic [ula_fx_cmd_pkg::DATA_W-1:0] push_in1,
	output logic [ula_fx_cmd_pkg::DATA_W-1:0] push_in2
);

	import ula_fx_cmd_pkg::*;

	logic [DATA_W-1:0] in1_q;
	logic [DATA_W-1:0] in2_q;
	logic              rdy_q;    // Shared ready pulse for AW and W
	logic              is_op;
	logic              mapped;
	logic              wr_ok;
	logic              wr_fire;

	assign is_op  = (awaddr == REG_OP);
	assign mapped = (awaddr == REG_IN1) || (awaddr == REG_IN2) || is_op;

	// Queue full holds off an op write
	assign wr_ok   = awvalid && wvalid && !bvalid && !rdy_q && !(is_op && full);
	assign wr_fire = rdy_q && awvalid && wvalid;

	assign awready = rdy_q;
	assign wready  = rdy_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rdy_q <= 1'b0;
		end else begin
			rdy_q <= wr_ok;
		end
	end

	// **************************************************
	// Write response
	// **************************************************
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bvalid <= 1'b0;
			bresp  <= RESP_OKAY;
		end else if (wr_fire) begin
			bvalid <= 1'b1;
			bresp  <= mapped ? RESP_OKAY : RESP_SLVERR;  // Result and status are read only
		end else if (bready) begin
			bvalid <= 1'b0;
		end
	end

	// Operand registers
	always_ff @(posedge clk) begin
		if (wr_fire && (awaddr == REG_IN1)) begin
			in1_q <= wdata;
		end
		if (wr_fire && (awaddr == REG_IN2)) begin
			in2_q <= wdata;
		end
	end

	// Op write carries the current operands into the queue
	assign push     = wr_fire && is_op;
	assign push_op  = wdata[OP_W-1:0];
	assign push_in1 = in1_q;
	assign push_in2 = in2_q;

endmodule

`default_nettype wire

//--- hw/ula_fx_float_unit.sv
/*
 * ULA FX float unit
 * Sign operations and multiply on the custom float format
 */

`default_nettype none

module ula_fx_float_unit (
	input  wire  [ula_fx_cmd_pkg::OP_W-1:0]   op,
	input  wire  [ula_fx_cmd_pkg::DATA_W-1:0] in1,
	input  wire  [ula_fx_cmd_pkg::DATA_W-1:0] in2,
	output ula_fx_num_pkg::ula_float_s         result
);

	import ula_fx_cmd_pkg::*;
	import ula_fx_num_pkg::*;

	// Positive stand-in for a negative input, only bit 30 set
	localparam ula_float_s FPST_WORD = '{s: 1'b0, e: {1'b1, {(EXP_W - 1){1'b0}}}, m: '0};

	ula_word_u               a;
	ula_word_u               b;
	logic signed [EXP_W-1:0] e1;
	logic signed [EXP_W-1:0] e2;
	logic signed [EXP_W:0]   e_sum;    // One guard bit for underflow
	logic [2*MAN_W-1:0]      m_prod;
	logic                    unf;
	ula_float_s              fmlt;

	assign a = in1;
	assign b = in2;

	// **************************************************
	// Multiply
	// **************************************************
	assign e1     = a.f.e;
	assign e2     = b.f.e;
	assign e_sum  = (EXP_W + 1)'(e1 + e2 + MAN_W);
	assign m_prod = a.f.m * b.f.m;
	assign unf    = (e_sum[EXP_W:EXP_W-1] == 2'b10);

	always_comb begin
		fmlt.s = a.f.s ^ b.f.s;
		fmlt.e = e_sum[EXP_W-1:0];
		fmlt.m = unf ? '0 : m_prod[2*MAN_W-1:MAN_W];   // Upper half of product
	end

	// Op select
	always_comb begin
		result = b.f;
		case (op)
			OP_FNEG: result.s = ~b.f.s;
			OP_FABS: result.s = 1'b0;
			OP_FSGN: result.s = a.f.s;                 // Magnitude from in2
			OP_FPST: begin
				if (b.f.s) begin
					result = FPST_WORD;
				end
			end
			OP_FMLT: result = fmlt;
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/ula_fx_int_unit.sv
/*
 * ULA FX integer unit
 * Arithmetic, bitwise, compare, boolean and shift ops on signed words
 */

`default_nettype none

module ula_fx_int_unit #(
	parameter int NU_GAIN = 64
) (
	input  wire         [ula_fx_cmd_pkg::OP_W-1:0]   op,
	input  wire  signed [ula_fx_cmd_pkg::DATA_W-1:0] in1,
	input  wire  signed [ula_fx_cmd_pkg::DATA_W-1:0] in2,
	output logic signed [ula_fx_cmd_pkg::DATA_W-1:0] result
);

	import ula_fx_cmd_pkg::*;

	localparam logic signed [DATA_W-1:0] GAIN = DATA_W'(NU_GAIN);
	localparam logic signed [DATA_W-1:0] ZERO = '0;

	logic [DATA_W-1:0] sh_amt;   // in2 taken as unsigned
	logic              sh_big;
	logic              neg2;

	// One bit truth value widened to a word
	function automatic logic signed [DATA_W-1:0] flag(input logic b);
		return {{(DATA_W - 1){1'b0}}, b};
	endfunction

	assign sh_amt = in2;
	assign sh_big = (sh_amt >= DATA_W);
	assign neg2   = in2[DATA_W-1];

	always_comb begin
		case (op)
			OP_NOP:  result = in2;
			OP_LOAD: result = in1;

			OP_ADD:  result = in1 + in2;
			OP_MLT:  result = in1 * in2;
			OP_DIV:  result = (in2 == '0) ? ZERO : in1 / in2;
			OP_MOD:  result = (in2 == '0) ? ZERO : in1 % in2;
			OP_NEG:  result = -in2;
			OP_NRM:  result = in2 / GAIN;               // Truncates toward zero
			OP_ABS:  result = neg2 ? -in2 : in2;
			OP_PST:  result = neg2 ? '0 : in2;
			OP_SGN:  result = (in1[DATA_W-1] == neg2) ? in2 : -in2;

			OP_OR:   result = in1 | in2;
			OP_AND:  result = in1 & in2;
			OP_INV:  result = ~in2;
			OP_XOR:  result = in1 ^ in2;

			OP_LES:  result = flag(in1 < in2);
			OP_GRE:  result = flag(in1 > in2);
			OP_EQU:  result = flag(in1 == in2);

			OP_LIN:  result = flag(in2 == '0);
			OP_LAN:  result = flag((in1 != '0) && (in2 != '0));
			OP_LOR:  result = flag((in1 != '0) || (in2 != '0));

			// Large amounts flush out
			OP_SHL:  result = sh_big ? '0 : in1 << sh_amt;
			OP_SHR:  result = sh_big ? '0 : in1 >> sh_amt;
			OP_SRS:  result = sh_big ? $signed({DATA_W{in1[DATA_W-1]}}) : in1 >>> sh_amt;

			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/ula_fx_num_pkg.sv
/*
 * ULA FX number format
 * Custom float fields and the integer / float views of one data word
 */

`default_nettype none

package ula_fx_num_pkg;

	localparam int MAN_W = 23;
	localparam int EXP_W = 8;

	// **************************************************
	// Float word layout
	// **************************************************

	// Sign, two's complement exponent, mantissa without hidden bit
	typedef struct packed {
		logic                    s;
		logic signed [EXP_W-1:0] e;
		logic        [MAN_W-1:0] m;
	} ula_float_s;

	// Same bits seen as a signed integer or as float fields
	typedef union packed {
		logic signed [ula_fx_cmd_pkg::DATA_W-1:0] i;
		ula_float_s                               f;
	} ula_word_u;

endpackage

`default_nettype wire

//--- hw/ula_fx_cmd_pkg.sv
/*
 * ULA FX command set
 * Op codes, field widths, register map and bus response codes
 */

`default_nettype none

package ula_fx_cmd_pkg;

	localparam int DATA_W = 32;
	localparam int OP_W   = 6;
	localparam int ADDR_W = 5;

	// **************************************************
	// Op codes, reference numbering
	// **************************************************
	localparam logic [OP_W-1:0] OP_NOP  = 6'd0;
	localparam logic [OP_W-1:0] OP_LOAD = 6'd1;
	localparam logic [OP_W-1:0] OP_ADD  = 6'd2;
	localparam logic [OP_W-1:0] OP_MLT  = 6'd3;
	localparam logic [OP_W-1:0] OP_DIV  = 6'd4;
	localparam logic [OP_W-1:0] OP_MOD  = 6'd5;
	localparam logic [OP_W-1:0] OP_NEG  = 6'd6;
	localparam logic [OP_W-1:0] OP_NRM  = 6'd7;   // Divide by NU_GAIN
	localparam logic [OP_W-1:0] OP_ABS  = 6'd8;
	localparam logic [OP_W-1:0] OP_PST  = 6'd9;   // Zero if negative
	localparam logic [OP_W-1:0] OP_SGN  = 6'd10;
	localparam logic [OP_W-1:0] OP_OR   = 6'd11;
	localparam logic [OP_W-1:0] OP_AND  = 6'd12;
	localparam logic [OP_W-1:0] OP_INV  = 6'd13;
	localparam logic [OP_W-1:0] OP_XOR  = 6'd14;
	localparam logic [OP_W-1:0] OP_LES  = 6'd15;
	localparam logic [OP_W-1:0] OP_GRE  = 6'd16;
	localparam logic [OP_W-1:0] OP_EQU  = 6'd17;
	localparam logic [OP_W-1:0] OP_LIN  = 6'd18;  // Logical not
	localparam logic [OP_W-1:0] OP_LAN  = 6'd19;
	localparam logic [OP_W-1:0] OP_LOR  = 6'd20;
	localparam logic [OP_W-1:0] OP_SHL  = 6'd21;
	localparam logic [OP_W-1:0] OP_SHR  = 6'd22;
	localparam logic [OP_W-1:0] OP_SRS  = 6'd23;  // Arithmetic right shift
	localparam logic [OP_W-1:0] OP_FNEG = 6'd29;
	localparam logic [OP_W-1:0] OP_FMLT = 6'd32;
	localparam logic [OP_W-1:0] OP_FSGN = 6'd36;
	localparam logic [OP_W-1:0] OP_FABS = 6'd38;
	localparam logic [OP_W-1:0] OP_FPST = 6'd41;

	// **************************************************
	// Register map
	// **************************************************
	localparam logic [ADDR_W-1:0] REG_IN1    = 5'h00;
	localparam logic [ADDR_W-1:0] REG_IN2    = 5'h04;
	localparam logic [ADDR_W-1:0] REG_OP     = 5'h08;  // Write launches a job
	localparam logic [ADDR_W-1:0] REG_RESULT = 5'h0C;  // Read frees the slot
	localparam logic [ADDR_W-1:0] REG_STATUS = 5'h10;

	localparam int STAT_VALID = 0;
	localparam int STAT_ZERO  = 1;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire
